//--- logic/rv_core_pkg.sv
//////////////////////////////////////////////////
// Shared types and constants for the RV32I execution
// subsystem. Imported by every RTL module.
//////////////////////////////////////////////////

`default_nettype none

package rv_core_pkg;

    typedef logic        [31:0] word_t;           // Instruction or data word.
    typedef logic signed [31:0] signed_word_t;    // Immediate after sign extension.
    typedef logic        [4:0]  register_index_t; // Register number x0..x31.
    typedef logic        [6:0]  funct7_t;
    typedef logic        [2:0]  funct3_t;

    // RV32I base opcodes, bits [6:0] of the word.
    typedef enum logic [6:0] {
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_SYSTEM = 7'b1110011
    } base_opcode_t;

    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;
    localparam funct3_t FUNCT3_DEFAULT = 3'b000; // SYSTEM with no CSR access.

    localparam funct7_t FUNCT7_SUB_SRA = 7'b0100000;

    // I-type immediates that select the SYSTEM instruction.
    localparam signed_word_t IMM_ECALL  = 32'sh000;
    localparam signed_word_t IMM_EBREAK = 32'sh001;
    localparam signed_word_t IMM_MRET   = 32'sh302;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_fn_t;

    // Decoder output.
    typedef struct packed {
        register_index_t rd;
        register_index_t rs1;
        register_index_t rs2;
        signed_word_t    imm;
        funct3_t         funct3;
        alu_fn_t         alu_fn;
        logic            use_pc;    // Operand A is the pc.
        logic            use_imm;   // Operand B is the immediate.
        logic            has_rd;
        logic            is_load;
        logic            is_store;
        logic            is_jump;
        logic            is_branch;
        logic            is_mret;
        logic            is_trap;   // ECALL or EBREAK.
    } instruction_t;

    // One retired instruction.
    typedef struct packed {
        word_t           pc;
        register_index_t rd;
        word_t           value;     // Written value, or 0.
        logic            wrote;
        logic            trap;
    } retire_t;

endpackage

`default_nettype wire

//--- logic/instr_apb_port.sv
//////////////////////////////////////////////////
// APB slave that feeds instruction words into the FIFO.
// INSTR at 0x0 pushes a word, STATUS at 0x4 reports the
// FIFO level and full flag.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module instr_apb_port
    import rv_core_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        psel,
    input  wire logic                        penable,
    input  wire logic                        pwrite,
    input  wire logic [3:0]                  paddr,
    input  wire word_t                       pwdata,
    input  wire logic                        full,
    input  wire logic [$clog2(FIFO_DEPTH):0] level,
    output word_t                            prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic                             push,
    output word_t                            push_data
);

    localparam int LEVEL_W = $clog2(FIFO_DEPTH) + 1;

    localparam logic [3:0] ADDR_INSTR  = 4'h0;
    localparam logic [3:0] ADDR_STATUS = 4'h4;

    typedef enum logic [1:0] {
        ACC_NONE,
        ACC_INSTR,
        ACC_STATUS,
        ACC_ERR
    } access_kind_t;

    access_kind_t kind_d;
    access_kind_t kind_q;  // Kind latched in the setup phase.
    logic         access;  // Access phase of a transfer.
    word_t        status;

    // Address and direction decode.
    always_comb begin
        if (paddr == ADDR_INSTR && pwrite) begin
            kind_d = ACC_INSTR;
        end else if (paddr == ADDR_STATUS && !pwrite) begin
            kind_d = ACC_STATUS;
        end else begin
            kind_d = ACC_ERR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kind_q <= ACC_NONE;
        end else if (psel && !penable) begin
            kind_q <= kind_d;
        end
    end

    assign access = psel && penable;
    assign status = {full, {(31 - LEVEL_W){1'b0}}, level};

    // A full FIFO stalls an INSTR write until a slot frees.
    assign pready    = !(access && kind_q == ACC_INSTR && full);
    assign pslverr   = access && kind_q == ACC_ERR;
    assign push      = access && kind_q == ACC_INSTR && !full; // One push per transfer.
    assign push_data = pwdata;
    assign prdata    = (access && kind_q == ACC_STATUS) ? status : '0;

endmodule

`default_nettype wire

//--- logic/instr_fifo.sv
//////////////////////////////////////////////////
// Synchronous FIFO of instruction words. Depth must be
// a power of two; head shows the oldest word.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module instr_fifo
    import rv_core_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        push,
    input  wire word_t                       push_data,
    input  wire logic                        pop,
    output word_t                            head,
    output logic                             empty,
    output logic                             full,
    output logic [$clog2(FIFO_DEPTH):0]      level
);

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    word_t             mem [FIFO_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [ADDR_W:0]   count;
    logic              do_push;
    logic              do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the power of two.
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Both or neither.
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == FIFO_DEPTH[ADDR_W:0]);
    assign level = count;

endmodule

`default_nettype wire

//--- logic/rv_decode.sv
//////////////////////////////////////////////////
// Combinational RV32I decoder. Slices one word into
// fields, immediate, ALU function and class flags.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rv_decode
    import rv_core_pkg::*;
(
    input  wire word_t  data,
    output instruction_t instr
);

    base_opcode_t    opcode;
    funct7_t         funct7;
    funct3_t         funct3;
    register_index_t rd;
    register_index_t rs1;
    register_index_t rs2;
    signed_word_t    imm;
    alu_fn_t         alu_fn;
    logic            is_system;
    logic            is_sub_sra; // funct7 selects SUB or SRA.

    assign opcode = base_opcode_t'(data[6:0]);
    assign rd     = data[11:7];
    assign funct3 = data[14:12];
    assign rs1    = data[19:15];
    assign rs2    = data[24:20];
    assign funct7 = data[31:25];

    assign is_system  = (opcode == OPCODE_SYSTEM) && (funct3 == FUNCT3_DEFAULT);
    assign is_sub_sra = (funct7 == FUNCT7_SUB_SRA);

    // Immediate per format, sign bit is always data[31].
    always_comb begin
        unique case (opcode)
            OPCODE_OP:                 imm = '0;
            OPCODE_LUI, OPCODE_AUIPC:  imm = {data[31:12], 12'b0};                       // U.
            OPCODE_STORE:              imm = {{20{data[31]}}, data[31:25], data[11:7]};  // S.
            OPCODE_BRANCH:             imm = {{20{data[31]}}, data[7], data[30:25],
                                              data[11:8], 1'b0};                         // B.
            OPCODE_JAL:                imm = {{12{data[31]}}, data[19:12], data[20],
                                              data[30:21], 1'b0};                        // J.
            default:                   imm = {{20{data[31]}}, data[31:20]};              // I.
        endcase
    end

    always_comb begin
        alu_fn = ALU_ADD; // Address and pc arithmetic.
        if (opcode == OPCODE_LUI) begin
            alu_fn = ALU_NOP;
        end else if (opcode == OPCODE_OP || opcode == OPCODE_OP_IMM) begin
            case (funct3)
                FUNCT3_ADD_SUB: alu_fn = (opcode == OPCODE_OP && is_sub_sra) ? ALU_SUB : ALU_ADD;
                FUNCT3_SLL:     alu_fn = ALU_SLL;
                FUNCT3_SLT:     alu_fn = ALU_SLT;
                FUNCT3_SLTU:    alu_fn = ALU_SLTU;
                FUNCT3_XOR:     alu_fn = ALU_XOR;
                FUNCT3_SRL_SRA: alu_fn = is_sub_sra ? ALU_SRA : ALU_SRL;
                FUNCT3_OR:      alu_fn = ALU_OR;
                default:        alu_fn = ALU_AND;
            endcase
        end
    end

    always_comb begin
        instr           = '0;
        instr.rd        = rd;
        instr.rs1       = rs1;
        instr.rs2       = rs2;
        instr.imm       = imm;
        instr.funct3    = funct3;
        instr.alu_fn    = alu_fn;
        instr.use_pc    = (opcode == OPCODE_AUIPC) || (opcode == OPCODE_JAL)
                          || (opcode == OPCODE_BRANCH);
        instr.use_imm   = (opcode != OPCODE_OP);
        instr.has_rd    = (opcode != OPCODE_BRANCH) && (opcode != OPCODE_STORE) && (rd != '0);
        instr.is_load   = (opcode == OPCODE_LOAD);
        instr.is_store  = (opcode == OPCODE_STORE);
        instr.is_jump   = (opcode == OPCODE_JAL) || (opcode == OPCODE_JALR);
        instr.is_branch = (opcode == OPCODE_BRANCH);
        instr.is_mret   = is_system && (imm == IMM_MRET);
        instr.is_trap   = is_system && (imm == IMM_ECALL || imm == IMM_EBREAK);
    end

endmodule

`default_nettype wire

//--- logic/rv_execute.sv
//////////////////////////////////////////////////
// Execution unit. Pops one word per cycle, runs the ALU
// on the register file and emits a retire record.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rv_execute
    import rv_core_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire word_t head,
    input  wire logic  empty,
    output logic       pop,
    output logic       retire_valid,
    output retire_t    retire
);

    instruction_t instr;
    base_opcode_t opcode;
    word_t        regs [32];
    word_t        pc;
    word_t        rs1_val;
    word_t        rs2_val;
    word_t        op_a;
    word_t        op_b;
    word_t        result;
    logic [4:0]   shamt;
    logic         is_alu_op;
    logic         reg_we;

    rv_decode rv_decode_inst (
        .data  (head),
        .instr (instr)
    );

    assign pop = !empty; // Never stalls.

    assign opcode    = base_opcode_t'(head[6:0]);
    assign is_alu_op = (opcode == OPCODE_OP) || (opcode == OPCODE_OP_IMM)
                       || (opcode == OPCODE_LUI) || (opcode == OPCODE_AUIPC);
    assign reg_we    = pop && is_alu_op && instr.has_rd;

    // x0 reads as zero.
    assign rs1_val = (instr.rs1 == '0) ? '0 : regs[instr.rs1];
    assign rs2_val = (instr.rs2 == '0) ? '0 : regs[instr.rs2];

    assign op_a  = instr.use_pc  ? pc : rs1_val;
    assign op_b  = instr.use_imm ? word_t'(instr.imm) : rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (instr.alu_fn)
            ALU_NOP:  result = word_t'(instr.imm); // LUI.
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {31'b0, op_a < op_b};
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            default:  result = '0;
        endcase
    end

    // Register file, cleared on reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            regs[instr.rd] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= pop;
            if (pop) pc <= pc + 32'd4;
        end
    end

    // Retire payload, qualified by retire_valid.
    always_ff @(posedge clk) begin
        if (pop) begin
            retire.pc    <= pc;
            retire.rd    <= instr.rd;
            retire.value <= reg_we ? result : '0;
            retire.wrote <= reg_we;
            retire.trap  <= instr.is_trap;
        end
    end

endmodule

`default_nettype wire

//--- logic/rv_exec_top.sv
//////////////////////////////////////////////////
// Top level. APB port feeds the instruction FIFO, which
// feeds the execution unit; retire records come out.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rv_exec_top
    import rv_core_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       psel,
    input  wire logic       penable,
    input  wire logic       pwrite,
    input  wire logic [3:0] paddr,
    input  wire word_t      pwdata,
    output word_t           prdata,
    output logic            pready,
    output logic            pslverr,
    output logic            retire_valid,
    output retire_t         retire
);

    logic                        push;
    word_t                       push_data;
    logic                        pop;
    word_t                       head;
    logic                        empty;
    logic                        full;
    logic [$clog2(FIFO_DEPTH):0] level;

    instr_apb_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) instr_apb_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .full      (full),
        .level     (level),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .push      (push),
        .push_data (push_data)
    );

    instr_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) instr_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .full      (full),
        .level     (level)
    );

    rv_execute rv_execute_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .head         (head),
        .empty        (empty),
        .pop          (pop),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

endmodule

`default_nettype wire

//--- tb/tb_rv_exec_top.sv
//////////////////////////////////////////////////
// Testbench for rv_exec_top. Replays the APB trace file,
// checks every APB response and the retire stream.
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_rv_exec_top
    import rv_core_pkg::*;
();

    localparam int    FIFO_DEPTH = 4;
    localparam string TRACE_FILE = "tb/rv_exec_trace.txt";

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic [3:0] paddr;
    word_t      pwdata;
    word_t      prdata;
    logic       pready;
    logic       pslverr;
    logic       retire_valid;
    retire_t    retire;

    byte        op_kind [$];    // W or R.
    logic [3:0] op_addr [$];
    word_t      op_data [$];    // Write data or expected read data.
    logic       op_err  [$];
    retire_t    expected_q [$];

    int check_errors;
    int other_errors;
    int cycle_count;
    int cycle_limit;

    rv_exec_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) rv_exec_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period.

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0d ns: %s is %08h, expected %08h",
                     $time, what, actual, expected);
            check_errors++;
        end
    endtask

    // Reads the whole trace before the run starts.
    task automatic load_trace();
        int      fd;
        int      fields;
        int      data_lines;
        string   line;
        byte     kind;
        word_t   f1;
        word_t   f2;
        word_t   f3;
        word_t   f4;
        word_t   f5;
        retire_t rec;
        data_lines = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
            fields = $sscanf(line, "%c %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
            data_lines++;
            if ((kind == "W" || kind == "R") && fields >= 4) begin
                op_kind.push_back(kind);
                op_addr.push_back(f1[3:0]);
                op_data.push_back(f2);
                op_err.push_back(f3[0]);
            end else if (kind == "E" && fields >= 6) begin
                rec.pc    = f1;
                rec.rd    = f2[4:0];
                rec.value = f3;
                rec.wrote = f4[0];
                rec.trap  = f5[0];
                expected_q.push_back(rec);
            end else begin
                $display("Trace line not understood: %s", line);
                other_errors++;
            end
        end
        $fclose(fd);
        cycle_limit = 20 * data_lines + 100;
    endtask

    // One APB transfer. Starts just after a rising edge.
    task automatic apb_access(input logic write, input logic [3:0] addr, input word_t data,
                              output word_t rdata, output logic err, output logic stalled);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        stalled = !pready;              // Wait state in the first access cycle.
        while (!pready) @(negedge clk); // Stalls while the FIFO is full.
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic replay_trace();
        word_t rdata;
        logic  err;
        logic  stalled;
        for (int i = 0; i < op_kind.size(); i++) begin
            apb_access(op_kind[i] == "W", op_addr[i], op_data[i], rdata, err, stalled);
            check_value(word_t'(err), word_t'(op_err[i]),
                        $sformatf("pslverr of %c access %0d to 0x%h", op_kind[i], i, op_addr[i]));
            if (op_kind[i] == "R") begin
                check_value(rdata, op_data[i],
                            $sformatf("prdata of read %0d from 0x%h", i, op_addr[i]));
            end
            // Reads and error accesses finish in the first access cycle.
            if (op_kind[i] == "R" || op_err[i]) begin
                check_value(word_t'(stalled), 32'd0,
                            $sformatf("wait state of %c access %0d", op_kind[i], i));
            end
        end
    endtask

    // Retire monitor. Samples away from the clock edge.
    always @(negedge clk) begin : retire_monitor
        retire_t want;
        if (rst_n && retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("Unexpected retire at %0d ns with pc %08h, no record was expected",
                         $time, retire.pc);
                other_errors++;
            end else begin
                want = expected_q.pop_front();
                check_value(retire.pc, want.pc, "retire pc");
                check_value(word_t'(retire.rd), word_t'(want.rd),
                            $sformatf("retire rd at pc %08h", want.pc));
                check_value(retire.value, want.value,
                            $sformatf("retire value at pc %08h", want.pc));
                check_value(word_t'(retire.wrote), word_t'(want.wrote),
                            $sformatf("retire wrote at pc %08h", want.pc));
                check_value(word_t'(retire.trap), word_t'(want.trap),
                            $sformatf("retire trap at pc %08h", want.pc));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d retire records still expected",
                     cycle_count, expected_q.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        int drain_cycles;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        check_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        cycle_limit  = 100;
        drain_cycles = 0;
        load_trace();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        replay_trace();
        while (expected_q.size() > 0 && drain_cycles < 20) begin
            @(negedge clk);
            drain_cycles++;
        end
        repeat (2) @(negedge clk); // Room for a stray retire.
        if (expected_q.size() > 0) begin
            $display("%0d retire records never appeared", expected_q.size());
            other_errors += expected_q.size();
        end
        $display("Errors: %0d failed checks, %0d other errors", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/rv_exec_trace.txt
# W addr data pslverr | R addr prdata pslverr : APB access and expected response, hex
# E pc rd value wrote trap : expected retire record in order, hex
R 4 00000000 0 # STATUS right after reset
W 8 deadbeef 1 # bad address
R 0 00000000 1 # INSTR is write only
R 8 00000000 1 # bad address
W 0 00500093 0 # addi x1, x0, 5
E 00000000 01 00000005 1 0
W 0 ffd00113 0 # addi x2, x0, -3
E 00000004 02 fffffffd 1 0
W 0 00112193 0 # slti x3, x2, 1
E 00000008 03 00000001 1 0
W 0 0f00c213 0 # xori x4, x1, 0xf0
E 0000000c 04 000000f5 1 0
W 0 ff00e293 0 # ori x5, x1, -16
E 00000010 05 fffffff5 1 0
W 0 07f17313 0 # andi x6, x2, 0x7f
E 00000014 06 0000007d 1 0
W 0 00409393 0 # slli x7, x1, 4
E 00000018 07 00000050 1 0
W 0 01c15413 0 # srli x8, x2, 28
E 0000001c 08 0000000f 1 0
W 0 40115493 0 # srai x9, x2, 1
E 00000020 09 fffffffe 1 0
R 4 00000000 0 # FIFO drained again
W 0 00108033 0 # add x0, x1, x1
E 00000024 00 00000000 0 0
W 0 00208533 0 # add x10, x1, x2
E 00000028 0a 00000002 1 0
W 0 402005b3 0 # sub x11, x0, x2
E 0000002c 0b 00000003 1 0
W 0 00112633 0 # slt x12, x2, x1
E 00000030 0c 00000001 1 0
W 0 001136b3 0 # sltu x13, x2, x1
E 00000034 0d 00000000 1 0
W 0 00c09733 0 # sll x14, x1, x12
E 00000038 0e 0000000a 1 0
W 0 007157b3 0 # srl x15, x2, x7
E 0000003c 0f 0000ffff 1 0
W 0 40715833 0 # sra x16, x2, x7
E 00000040 10 ffffffff 1 0
W 0 12345937 0 # lui x18, 0x12345
E 00000044 12 12345000 1 0
W 0 00001997 0 # auipc x19, 1
E 00000048 13 00001048 1 0
W 0 00112423 0 # sw x1, 8(x2)
E 0000004c 08 00000000 0 0
W 0 00208863 0 # beq x1, x2, 16
E 00000050 10 00000000 0 0
W 0 0040aa83 0 # lw x21, 4(x1)
E 00000054 15 00000000 0 0
W 0 008000ef 0 # jal x1, 8
E 00000058 01 00000000 0 0
W 0 00000073 0 # ecall
E 0000005c 00 00000000 0 1
W 0 00100073 0 # ebreak
E 00000060 00 00000000 0 1
W 0 30200073 0 # mret
E 00000064 00 00000000 0 0
R 4 00000000 0 # idle at the end

//--- sim.f
logic/rv_core_pkg.sv
logic/instr_apb_port.sv
logic/instr_fifo.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_exec_top.sv
tb/tb_rv_exec_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
# Exits non-zero on a build error, a simulator error or a failing test.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_rv_exec_top \
    -Mdir obj_dir -o tb_rv_exec_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_rv_exec_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
